// File: async_fifo.f
+incdir+rtl
rtl/afifo_pkg.sv
rtl/fifo_ptr_counter.sv
rtl/ptr_sync.sv
rtl/fifo_mem.sv
rtl/fifo_control.sv
rtl/async_fifo.sv
tests/tb_clock_gen.sv
tests/tb_async_fifo.sv

// File: rtl/afifo_macros.svh
`ifndef AFIFO_MACROS_SVH
`define AFIFO_MACROS_SVH

// width of one stored word
`define AFIFO_DATA_WIDTH 8

// the depth is always two to the power of the address width
`define AFIFO_ADDR_WIDTH 4
`define AFIFO_DEPTH (1 << `AFIFO_ADDR_WIDTH)

// almost-full is raised when the free slots drop to this margin
`define AFIFO_ALMOST_FULL_MARGIN 2
// almost-empty is raised when a non-empty FIFO holds this many words or fewer
`define AFIFO_ALMOST_EMPTY_MARGIN 2

`endif

// File: rtl/afifo_pkg.sv
`default_nettype none

`include "afifo_macros.svh"

package afifo_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage and addressing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one word as it sits in the memory
    typedef logic [`AFIFO_DATA_WIDTH-1:0] fifo_data_t;

    // memory address without the wrap bit
    typedef logic [`AFIFO_ADDR_WIDTH-1:0] fifo_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the extra top bit tells a full FIFO from an empty one
    // the same type carries both the binary and the Gray form
    typedef logic [`AFIFO_ADDR_WIDTH:0] fifo_ptr_t;

    // one bit wider than an address so a full FIFO can report its depth
    typedef logic [`AFIFO_ADDR_WIDTH:0] fifo_count_t;

endpackage : afifo_pkg

`default_nettype wire

// File: rtl/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo (
    input  logic                   i_wr_clk,
    input  logic                   i_wr_rst_n,
    input  logic                   i_wr_en,
    input  afifo_pkg::fifo_data_t  i_wr_data,
    input  logic                   i_rd_clk,
    input  logic                   i_rd_rst_n,
    input  logic                   i_rd_en,
    output afifo_pkg::fifo_data_t  o_rd_data,
    output logic                   o_wr_full,
    output logic                   o_wr_almost_full,
    output logic                   o_rd_empty,
    output logic                   o_rd_almost_empty,
    output afifo_pkg::fifo_count_t o_rd_count
);

    import afifo_pkg::*;

    logic       wr_accept;
    logic       rd_accept;
    fifo_ptr_t  wr_ptr_next;
    fifo_ptr_t  wr_ptr_gray;
    fifo_addr_t wr_addr;
    fifo_ptr_t  rd_ptr_next;
    fifo_ptr_t  rd_ptr_gray;
    fifo_addr_t rd_addr;
    fifo_ptr_t  wdom_rd_ptr;
    fifo_ptr_t  rdom_wr_ptr;

    // the registered flags gate the strobes here and nowhere else
    assign wr_accept = i_wr_en && !o_wr_full;
    assign rd_accept = i_rd_en && !o_rd_empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // only the next value and the address of the binary pointer are needed
    fifo_ptr_counter u_wr_ptr (
        .i_clk          (i_wr_clk),
        .i_rst_n        (i_wr_rst_n),
        .i_inc          (wr_accept),
        .o_ptr_bin      (),
        .o_ptr_bin_next (wr_ptr_next),
        .o_ptr_gray     (wr_ptr_gray),
        .o_addr         (wr_addr)
    );

    // read pointer brought over into the write clock
    ptr_sync u_rd2wr_sync (
        .i_clk      (i_wr_clk),
        .i_rst_n    (i_wr_rst_n),
        .i_ptr_gray (rd_ptr_gray),
        .o_ptr_bin  (wdom_rd_ptr)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    fifo_ptr_counter u_rd_ptr (
        .i_clk          (i_rd_clk),
        .i_rst_n        (i_rd_rst_n),
        .i_inc          (rd_accept),
        .o_ptr_bin      (),
        .o_ptr_bin_next (rd_ptr_next),
        .o_ptr_gray     (rd_ptr_gray),
        .o_addr         (rd_addr)
    );

    ptr_sync u_wr2rd_sync (
        .i_clk      (i_rd_clk),
        .i_rst_n    (i_rd_rst_n),
        .i_ptr_gray (wr_ptr_gray),
        .o_ptr_bin  (rdom_wr_ptr)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage and flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    fifo_mem u_mem (
        .i_wr_clk   (i_wr_clk),
        .i_wr_en    (wr_accept),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (i_wr_data),
        .i_rd_clk   (i_rd_clk),
        .i_rd_rst_n (i_rd_rst_n),
        .i_rd_en    (rd_accept),
        .i_rd_addr  (rd_addr),
        .o_rd_data  (o_rd_data)
    );

    fifo_control u_ctrl (
        .i_wr_clk          (i_wr_clk),
        .i_wr_rst_n        (i_wr_rst_n),
        .i_rd_clk          (i_rd_clk),
        .i_rd_rst_n        (i_rd_rst_n),
        .i_wr_ptr_next     (wr_ptr_next),
        .i_wdom_rd_ptr     (wdom_rd_ptr),
        .i_rd_ptr_next     (rd_ptr_next),
        .i_rdom_wr_ptr     (rdom_wr_ptr),
        .o_wr_full         (o_wr_full),
        .o_wr_almost_full  (o_wr_almost_full),
        .o_rd_empty        (o_rd_empty),
        .o_rd_almost_empty (o_rd_almost_empty),
        .o_rd_count        (o_rd_count)
    );

endmodule : async_fifo

`default_nettype wire

// File: rtl/fifo_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "afifo_macros.svh"

module fifo_control (
    input  logic                   i_wr_clk,
    input  logic                   i_wr_rst_n,
    input  logic                   i_rd_clk,
    input  logic                   i_rd_rst_n,
    input  afifo_pkg::fifo_ptr_t   i_wr_ptr_next,
    input  afifo_pkg::fifo_ptr_t   i_wdom_rd_ptr,
    input  afifo_pkg::fifo_ptr_t   i_rd_ptr_next,
    input  afifo_pkg::fifo_ptr_t   i_rdom_wr_ptr,
    output logic                   o_wr_full,
    output logic                   o_wr_almost_full,
    output logic                   o_rd_empty,
    output logic                   o_rd_almost_empty,
    output afifo_pkg::fifo_count_t o_rd_count
);

    import afifo_pkg::*;

    localparam int          ADDR_W    = `AFIFO_ADDR_WIDTH;
    localparam fifo_count_t DEPTH_C   = fifo_count_t'(`AFIFO_DEPTH);
    localparam fifo_count_t AF_MARGIN = fifo_count_t'(`AFIFO_ALMOST_FULL_MARGIN);
    localparam fifo_count_t AE_MARGIN = fifo_count_t'(`AFIFO_ALMOST_EMPTY_MARGIN);

    logic        wdom_wrap_xor;
    logic        rdom_wrap_xor;
    fifo_count_t wdom_occ;
    fifo_count_t rdom_occ;
    logic        wr_full_d;
    logic        wr_almost_full_d;
    logic        rd_empty_d;
    logic        rd_almost_empty_d;

    // words held between a write pointer and a read pointer
    // when the wrap bits differ the writer has lapped the reader once
    function automatic fifo_count_t occupancy(logic wrap, fifo_ptr_t wr, fifo_ptr_t rd);
        fifo_count_t wr_lo;
        fifo_count_t rd_lo;
        wr_lo = fifo_count_t'(fifo_addr_t'(wr));
        rd_lo = fifo_count_t'(fifo_addr_t'(rd));
        if (wrap) begin
            return DEPTH_C - rd_lo + wr_lo;
        end
        return wr_lo - rd_lo;
    endfunction

    assign wdom_wrap_xor = i_wr_ptr_next[ADDR_W] ^ i_wdom_rd_ptr[ADDR_W];
    assign rdom_wrap_xor = i_rd_ptr_next[ADDR_W] ^ i_rdom_wr_ptr[ADDR_W];

    assign wdom_occ = occupancy(wdom_wrap_xor, i_wr_ptr_next, i_wdom_rd_ptr);
    assign rdom_occ = occupancy(rdom_wrap_xor, i_rdom_wr_ptr, i_rd_ptr_next);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write domain flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // same address on opposite laps means every slot is taken
    assign wr_full_d = wdom_wrap_xor &&
                       (fifo_addr_t'(i_wr_ptr_next) == fifo_addr_t'(i_wdom_rd_ptr));
    assign wr_almost_full_d = (DEPTH_C - wdom_occ) <= AF_MARGIN;

    always_ff @(posedge i_wr_clk, negedge i_wr_rst_n) begin
        if (!i_wr_rst_n) begin
            o_wr_full        <= 1'b0;
            o_wr_almost_full <= 1'b0;
        end else begin
            o_wr_full        <= wr_full_d;
            o_wr_almost_full <= wr_almost_full_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read domain flags and count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // same address on the same lap means nothing is stored
    assign rd_empty_d = !rdom_wrap_xor &&
                        (fifo_addr_t'(i_rd_ptr_next) == fifo_addr_t'(i_rdom_wr_ptr));
    assign rd_almost_empty_d = (rdom_occ != '0) && (rdom_occ <= AE_MARGIN);

    always_ff @(posedge i_rd_clk, negedge i_rd_rst_n) begin
        if (!i_rd_rst_n) begin
            o_rd_empty        <= 1'b1;
            o_rd_almost_empty <= 1'b0;
            o_rd_count        <= '0;
        end else begin
            o_rd_empty        <= rd_empty_d;
            o_rd_almost_empty <= rd_almost_empty_d;
            o_rd_count        <= rdom_occ;
        end
    end

endmodule : fifo_control

`default_nettype wire

// File: rtl/fifo_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "afifo_macros.svh"

module fifo_mem (
    input  logic                  i_wr_clk,
    input  logic                  i_wr_en,
    input  afifo_pkg::fifo_addr_t i_wr_addr,
    input  afifo_pkg::fifo_data_t i_wr_data,
    input  logic                  i_rd_clk,
    input  logic                  i_rd_rst_n,
    input  logic                  i_rd_en,
    input  afifo_pkg::fifo_addr_t i_rd_addr,
    output afifo_pkg::fifo_data_t o_rd_data
);

    import afifo_pkg::*;

    fifo_data_t mem [`AFIFO_DEPTH];

    // write port lives entirely in the write clock domain
    always_ff @(posedge i_wr_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // the popped word stays on the output until the next accepted read
    always_ff @(posedge i_rd_clk, negedge i_rd_rst_n) begin
        if (!i_rd_rst_n) begin
            o_rd_data <= '0;
        end else if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule : fifo_mem

`default_nettype wire

// File: rtl/fifo_ptr_counter.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_ptr_counter (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_inc,
    output afifo_pkg::fifo_ptr_t  o_ptr_bin,
    output afifo_pkg::fifo_ptr_t  o_ptr_bin_next,
    output afifo_pkg::fifo_ptr_t  o_ptr_gray,
    output afifo_pkg::fifo_addr_t o_addr
);

    import afifo_pkg::*;

    fifo_ptr_t ptr_gray_next;

    // the next binary value goes straight to the flag logic so the
    // registered flags line up with the pointer update
    assign o_ptr_bin_next = o_ptr_bin + fifo_ptr_t'(i_inc);

    // binary to Gray on the next value
    assign ptr_gray_next = o_ptr_bin_next ^ (o_ptr_bin_next >> 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointer registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the Gray copy is a flop output so only one bit moves per step
    // when the other clock domain samples it
    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ptr_bin  <= '0;
            o_ptr_gray <= '0;
        end else begin
            o_ptr_bin  <= o_ptr_bin_next;
            o_ptr_gray <= ptr_gray_next;
        end
    end

    // the wrap bit is dropped to address the memory
    assign o_addr = fifo_addr_t'(o_ptr_bin);

endmodule : fifo_ptr_counter

`default_nettype wire

// File: rtl/ptr_sync.sv
`timescale 1ns/1ps
`default_nettype none

module ptr_sync (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  afifo_pkg::fifo_ptr_t i_ptr_gray,
    output afifo_pkg::fifo_ptr_t o_ptr_bin
);

    import afifo_pkg::*;

    localparam int PTR_W = $bits(fifo_ptr_t);

    fifo_ptr_t gray_meta;
    fifo_ptr_t gray_sync;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // two-flop synchronizer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the first stage may go metastable and is never read by logic
    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            gray_meta <= '0;
            gray_sync <= '0;
        end else begin
            gray_meta <= i_ptr_gray;
            gray_sync <= gray_meta;
        end
    end

    // each binary bit is the XOR of all Gray bits at or above it
    always_comb begin
        for (int i = 0; i < PTR_W; i++) begin
            o_ptr_bin[i] = ^(gray_sync >> i);
        end
    end

endmodule : ptr_sync

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the async FIFO testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f async_fifo.f \
    --top-module tb_async_fifo -o tb_async_fifo \
    || { echo "verilator build failed"; exit 1; }

{ ./obj_dir/tb_async_fifo > "$LOG" 2>&1 || true; } && cat "$LOG"

grep -q "Simulation finished: FAIL" "$LOG" && { echo "run failed, see $LOG"; exit 1; }
grep -q "Simulation finished: PASS" "$LOG" || { echo "run gave no result, see $LOG"; exit 1; }
echo "run passed"

// File: tests/async_fifo_tests.txt
# write <count> <first data hex> | read <count> | drop <data hex> | burst <cycles>
# expect <occupancy> <full> <almost_full> <empty> <almost_empty>
expect 0 0 0 1 0
write 1 10
expect 1 0 0 0 1
write 1 11
expect 2 0 0 0 1
write 1 12
expect 3 0 0 0 0
read 2
expect 1 0 0 0 1
read 1
expect 0 0 0 1 0
write 13 20
expect 13 0 0 0 0
write 1 40
expect 14 0 1 0 0
write 1 41
expect 15 0 1 0 0
write 1 42
expect 16 1 1 0 0
drop ee
read 16
expect 0 0 0 1 0
burst 400
expect 0 0 0 1 0

// File: tests/tb_async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "afifo_macros.svh"

module tb_async_fifo;

    import afifo_pkg::*;

    localparam int          TIMEOUT_CYCLES = 60;
    localparam int unsigned SEED           = 25274;

    logic        rd_clk;
    logic        rd_rst_n;
    logic        wr_clk;
    logic        wr_rst_n;
    logic        wr_en;
    fifo_data_t  wr_data;
    logic        rd_en;
    fifo_data_t  rd_data;
    logic        wr_full;
    logic        wr_afull;
    logic        rd_empty;
    logic        rd_aempty;
    fifo_count_t rd_count;

    // words the DUT should hold with the oldest at the front
    fifo_data_t  model_q[$];
    int unsigned wr_rng;
    int unsigned rd_rng;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_rd_clk_gen (
        .o_clk   (rd_clk),
        .o_rst_n (rd_rst_n)
    );

    tb_clock_gen #(.PERIOD_NS(14), .RESET_CYCLES(2)) u_wr_clk_gen (
        .o_clk   (wr_clk),
        .o_rst_n (wr_rst_n)
    );

    async_fifo UUT (
        .i_wr_clk          (wr_clk),
        .i_wr_rst_n        (wr_rst_n),
        .i_wr_en           (wr_en),
        .i_wr_data         (wr_data),
        .i_rd_clk          (rd_clk),
        .i_rd_rst_n        (rd_rst_n),
        .i_rd_en           (rd_en),
        .o_rd_data         (rd_data),
        .o_wr_full         (wr_full),
        .o_wr_almost_full  (wr_afull),
        .o_rd_empty        (rd_empty),
        .o_rd_almost_empty (rd_aempty),
        .o_rd_count        (rd_count)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // error reporting and compares
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_data(input fifo_data_t got, input fifo_data_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: o_rd_data expected %h got %h", $time, exp, got);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s expected %b got %b", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_count(input fifo_count_t got, input fifo_count_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: o_rd_count expected %0d got %0d", $time, exp, got);
            stop_run();
        end
    endtask

    // 32-bit LCG whose upper bits are the useful ones
    function automatic int unsigned next_rand(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write and read sides
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic write_words(input int count, input fifo_data_t first);
        int cycles;
        @(negedge wr_clk);
        for (int i = 0; i < count; i++) begin
            cycles = 0;
            while (wr_full) begin
                @(negedge wr_clk);
                cycles++;
                if (cycles > TIMEOUT_CYCLES) begin
                    report_failure("timed out waiting for o_wr_full to drop");
                end
            end
            wr_en   = 1'b1;
            wr_data = first + fifo_data_t'(i);
            @(negedge wr_clk);
            wr_en = 1'b0;
            model_q.push_back(wr_data);
        end
    endtask

    // the word is offered while full, so it must not show up later
    task automatic write_dropped(input fifo_data_t data);
        @(negedge wr_clk);
        check_flag("o_wr_full", wr_full, 1'b1);
        wr_en   = 1'b1;
        wr_data = data;
        @(negedge wr_clk);
        wr_en = 1'b0;
    endtask

    // called on a falling read edge and returns one read clock after the accept
    task automatic read_one();
        int         cycles;
        fifo_data_t exp;
        cycles = 0;
        while (rd_empty) begin
            @(negedge rd_clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_failure("timed out waiting for o_rd_empty to drop");
            end
        end
        rd_en = 1'b1;
        @(negedge rd_clk);
        rd_en = 1'b0;
        if (model_q.size() == 0) begin
            report_failure("a read was accepted while the model holds no word");
        end
        exp = model_q.pop_front();
        check_data(rd_data, exp);
    endtask

    task automatic read_words(input int count);
        @(negedge rd_clk);
        for (int i = 0; i < count; i++) begin
            read_one();
        end
    endtask

    task automatic expect_state(input int occ, input logic full, input logic afull,
                                input logic empty, input logic aempty);
        int   cycles;
        logic m_full;
        logic m_afull;
        logic m_empty;
        logic m_aempty;
        // margin rules applied to the model occupancy
        m_full   = (model_q.size() == `AFIFO_DEPTH);
        m_afull  = (`AFIFO_DEPTH - model_q.size()) <= `AFIFO_ALMOST_FULL_MARGIN;
        m_empty  = (model_q.size() == 0);
        m_aempty = (model_q.size() > 0) && (model_q.size() <= `AFIFO_ALMOST_EMPTY_MARGIN);
        if (occ != model_q.size()) begin
            report_failure("tests file occupancy differs from the model");
        end
        if ({full, afull, empty, aempty} != {m_full, m_afull, m_empty, m_aempty}) begin
            report_failure("tests file flags differ from the margin rules");
        end
        cycles = 0;
        @(negedge rd_clk);
        while (((rd_count != fifo_count_t'(occ)) ||
                ({wr_full, wr_afull, rd_empty, rd_aempty} != {full, afull, empty, aempty}))
               && cycles < TIMEOUT_CYCLES) begin
            @(negedge rd_clk);
            cycles++;
        end
        check_count(rd_count, fifo_count_t'(occ));
        check_flag("o_wr_full", wr_full, full);
        check_flag("o_wr_almost_full", wr_afull, afull);
        check_flag("o_rd_empty", rd_empty, empty);
        check_flag("o_rd_almost_empty", rd_aempty, aempty);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random burst on both clocks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic burst_writer(input int cycles);
        logic       take;
        fifo_data_t data;
        @(negedge wr_clk);
        for (int i = 0; i < cycles; i++) begin
            wr_rng  = next_rand(wr_rng);
            take    = wr_rng[16] && !wr_full;
            data    = fifo_data_t'(wr_rng >> 8);
            wr_en   = take;
            wr_data = data;
            @(negedge wr_clk);
            if (take) begin
                model_q.push_back(data);
            end
        end
        wr_en = 1'b0;
    endtask

    task automatic burst_reader(input int cycles);
        logic       take;
        fifo_data_t exp;
        @(negedge rd_clk);
        for (int i = 0; i < cycles; i++) begin
            rd_rng = next_rand(rd_rng);
            take   = rd_rng[17] && !rd_empty;
            rd_en  = take;
            @(negedge rd_clk);
            if (take) begin
                if (model_q.size() == 0) begin
                    report_failure("a burst read was accepted while the model is empty");
                end
                exp = model_q.pop_front();
                check_data(rd_data, exp);
            end
        end
        rd_en = 1'b0;
    endtask

    task automatic random_burst(input int cycles);
        fork
            burst_writer(cycles);
            burst_reader(cycles);
        join
        // whatever is left gets drained so the FIFO ends empty
        @(negedge rd_clk);
        while (model_q.size() > 0) begin
            read_one();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_command(input string line);
        logic [95:0] word;
        int          fields;
        int          a0;
        int          a1;
        int          a2;
        int          a3;
        int          a4;
        case (line.getc(0))
            "w": begin
                fields = $sscanf(line, "%s %d %h", word, a0, a1);
                if (fields != 3) report_failure({"bad write line: ", line});
                write_words(a0, fifo_data_t'(a1));
            end
            "r": begin
                fields = $sscanf(line, "%s %d", word, a0);
                if (fields != 2) report_failure({"bad read line: ", line});
                read_words(a0);
            end
            "d": begin
                fields = $sscanf(line, "%s %h", word, a0);
                if (fields != 2) report_failure({"bad drop line: ", line});
                write_dropped(fifo_data_t'(a0));
            end
            "e": begin
                fields = $sscanf(line, "%s %d %d %d %d %d", word, a0, a1, a2, a3, a4);
                if (fields != 6) report_failure({"bad expect line: ", line});
                expect_state(a0, a1 != 0, a2 != 0, a3 != 0, a4 != 0);
            end
            "b": begin
                fields = $sscanf(line, "%s %d", word, a0);
                if (fields != 2) report_failure({"bad burst line: ", line});
                random_burst(a0);
            end
            default: report_failure({"unknown command: ", line});
        endcase
    endtask

    initial begin
        int    fd;
        int    cycles;
        int    commands;
        string line;
        wr_en       = 1'b0;
        wr_data     = '0;
        rd_en       = 1'b0;
        commands    = 0;
        wr_rng      = SEED;
        rd_rng      = next_rand(SEED);
        fd = $fopen("tests/async_fifo_tests.txt", "r");
        if (fd == 0) report_failure("could not open tests/async_fifo_tests.txt");
        cycles = 0;
        while (!(rd_rst_n && wr_rst_n)) begin
            @(negedge rd_clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) report_failure("the resets were never released");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                run_command(line);
                commands++;
            end
        end
        $fclose(fd);
        if (commands == 0) report_failure("the tests file held no commands");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : tb_async_fifo

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic o_clk,
    output logic o_rst_n
);

    localparam int HALF_NS = PERIOD_NS / 2;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_NS) o_clk = ~o_clk;
    end

    // reset is let go on a falling edge so it never meets a rising one
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire
